//--- source/issue_pkg.sv
// ------------------------------
// shared types and constants of the issue stage
// functional-unit codes, field widths, register count
// ------------------------------

package issue_pkg;

  // ------------------------------
  // architectural sizes
  // ------------------------------

  // register address, x0..x31
  localparam int unsigned REG_ADDR_W = 5;

  // architectural integer registers
  localparam int unsigned NR_REGS = 32;

  // ------------------------------
  // instruction fields
  // ------------------------------

  // opaque operation code, decoded by the units themselves
  localparam int unsigned FU_OP_W = 8;

  // scoreboard transaction id
  localparam int unsigned TRANS_ID_W = 3;

  // zimm comes from the rs1 field of CSR immediate forms
  localparam int unsigned ZIMM_W = 5;

  // ------------------------------
  // functional units
  // ------------------------------

  // unit an instruction needs
  // also the clobber table entry, NONE marks a free register
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    LOAD      = 3'd1,
    STORE     = 3'd2,
    ALU       = 3'd3,
    CTRL_FLOW = 3'd4,
    MULT      = 3'd5,
    CSR       = 3'd6
  } fu_t;

endpackage

//--- source/issue_ctrl.sv
// ------------------------------
// issue decision: structural, RAW and WAW checks
// drives the acknowledge and the forward selects
// ------------------------------

module issue_ctrl (
  // instruction from the scoreboard
  input  logic                               instr_valid_i,
  input  issue_pkg::fu_t                     instr_fu_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]   instr_rs1_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]   instr_rs2_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]   instr_rd_i,
  input  logic                               use_zimm_i,
  input  logic                               ex_valid_i,
  // per-register producer of the pending write
  input  issue_pkg::fu_t [issue_pkg::NR_REGS-1:0] rd_clobber_i,
  // scoreboard result availability
  input  logic                               rs1_fwd_valid_i,
  input  logic                               rs2_fwd_valid_i,
  // commit port, write address only
  input  logic                               commit_we_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]   commit_waddr_i,
  // unit ready levels
  input  logic                               flu_ready_i,
  input  logic                               lsu_ready_i,
  // a mult pulse is on the fixed-latency bus this cycle
  input  logic                               mult_issued_i,
  output logic                               issue_ack_o,
  output logic                               fwd_rs1_o,
  output logic                               fwd_rs2_o
);

  import issue_pkg::*;

  // busy per unit class
  logic busy_lsu;
  logic busy_flu;
  logic busy_mult;
  // busy level of the unit this instruction needs
  logic fu_busy;

  // producers pending on the source and destination registers
  fu_t  rs1_producer;
  fu_t  rs2_producer;
  fu_t  rd_producer;

  logic stall;
  logic waw_clear;

  // ------------------------------
  // structural hazards
  // ------------------------------

  // load and store share the lsu
  assign busy_lsu  = !lsu_ready_i;
  // a mult in flight owns the result slot next cycle, only another mult may follow
  assign busy_flu  = !flu_ready_i || mult_issued_i;
  assign busy_mult = !flu_ready_i;

  always_comb begin
    unique case (instr_fu_i)
      LOAD, STORE:         fu_busy = busy_lsu;
      ALU, CTRL_FLOW, CSR: fu_busy = busy_flu;
      MULT:                fu_busy = busy_mult;
      default:             fu_busy = 1'b0;
    endcase
  end

  // ------------------------------
  // RAW hazards
  // ------------------------------

  assign rs1_producer = rd_clobber_i[instr_rs1_i];
  assign rs2_producer = rd_clobber_i[instr_rs2_i];

  always_comb begin
    stall     = 1'b0;
    fwd_rs1_o = 1'b0;
    fwd_rs2_o = 1'b0;

    // zimm is an immediate, nothing to wait for on rs1
    if (!use_zimm_i && rs1_producer != NONE) begin
      // csr results only reach us through the register file
      if (rs1_fwd_valid_i && rs1_producer != CSR) begin
        fwd_rs1_o = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end

    if (rs2_producer != NONE) begin
      if (rs2_fwd_valid_i && rs2_producer != CSR) begin
        fwd_rs2_o = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
  end

  // ------------------------------
  // WAW hazard and acknowledge
  // ------------------------------

  assign rd_producer = rd_clobber_i[instr_rd_i];

  // rd free, or its last writer retires through the commit port right now
  assign waw_clear = (rd_producer == NONE) ||
                     (commit_we_i && commit_waddr_i == instr_rd_i);

  always_comb begin
    issue_ack_o = 1'b0;
    if (instr_valid_i) begin
      if (!stall && !fu_busy && waw_clear) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less ops just leave the scoreboard
      if (ex_valid_i || instr_fu_i == NONE) begin
        issue_ack_o = 1'b1;
      end
    end
  end

endmodule

//--- source/int_regfile.sv
// ------------------------------
// integer register file, 2 read / 1 write
// ------------------------------

module int_regfile #(
  parameter int unsigned XLEN = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // combinational read ports
  input  logic [issue_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0] raddr_b_i,
  // write port, visible from the next cycle
  input  logic                             we_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]                  wdata_i,
  output logic [XLEN-1:0]                  rdata_a_o,
  output logic [XLEN-1:0]                  rdata_b_o
);

  import issue_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:NR_REGS-1];

  // address decode, unmatched addresses (x0) read zero
  function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] data;
    data = '0;
    for (int i = 1; i < NR_REGS; i++) begin
      if (addr == REG_ADDR_W'(i)) begin
        data = regs_q[i];
      end
    end
    return data;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      // writes to x0 dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = read_reg(raddr_a_i);
  assign rdata_b_o = read_reg(raddr_b_i);

endmodule

//--- source/operand_dispatch.sv
// ------------------------------
// operand select and ID/EX registers
// one-hot unit valid pulses, branch info
// ------------------------------

module operand_dispatch #(
  parameter int unsigned XLEN = 32,
  parameter int unsigned VLEN = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // decisions from issue control
  input  logic                             issue_ack_i,
  input  logic                             fwd_rs1_i,
  input  logic                             fwd_rs2_i,
  // register file and scoreboard values
  input  logic [XLEN-1:0]                  rdata_a_i,
  input  logic [XLEN-1:0]                  rdata_b_i,
  input  logic [XLEN-1:0]                  rs1_fwd_i,
  input  logic [XLEN-1:0]                  rs2_fwd_i,
  // instruction
  input  logic                             instr_valid_i,
  input  logic                             ex_valid_i,
  input  issue_pkg::fu_t                   instr_fu_i,
  input  logic [issue_pkg::FU_OP_W-1:0]    instr_op_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0] instr_rs1_i,
  input  logic [XLEN-1:0]                  instr_imm_i,
  input  logic [VLEN-1:0]                  instr_pc_i,
  input  logic [issue_pkg::TRANS_ID_W-1:0] instr_trans_id_i,
  input  logic                             use_imm_i,
  input  logic                             use_pc_i,
  input  logic                             use_zimm_i,
  input  logic                             is_compressed_i,
  input  logic                             bp_taken_i,
  // ID/EX outputs
  output logic [XLEN-1:0]                  operand_a_o,
  output logic [XLEN-1:0]                  operand_b_o,
  output logic [XLEN-1:0]                  imm_o,
  output issue_pkg::fu_t                   fu_o,
  output logic [issue_pkg::FU_OP_W-1:0]    op_o,
  output logic [issue_pkg::TRANS_ID_W-1:0] trans_id_o,
  output logic                             alu_valid_o,
  output logic                             branch_valid_o,
  output logic                             mult_valid_o,
  output logic                             lsu_valid_o,
  output logic                             csr_valid_o,
  output logic                             mult_issued_o,
  output logic [VLEN-1:0]                  pc_o,
  output logic                             is_compressed_o,
  output logic                             bp_taken_o
);

  import issue_pkg::*;

  logic [XLEN-1:0] operand_a_d;
  logic [XLEN-1:0] operand_b_d;
  // instruction goes to a unit this cycle
  logic            dispatch;

  // ------------------------------
  // operand select
  // ------------------------------

  always_comb begin
    // rs1: scoreboard beats regfile, pc beats both, zimm beats pc
    operand_a_d = fwd_rs1_i ? rs1_fwd_i : rdata_a_i;
    if (use_pc_i) begin
      operand_a_d = XLEN'($signed(instr_pc_i));
    end
    if (use_zimm_i) begin
      operand_a_d = XLEN'(instr_rs1_i[ZIMM_W-1:0]);
    end

    // store and branch keep rs2, the imm travels separately
    operand_b_d = fwd_rs2_i ? rs2_fwd_i : rdata_b_i;
    if (use_imm_i && instr_fu_i != STORE && instr_fu_i != CTRL_FLOW) begin
      operand_b_d = instr_imm_i;
    end
  end

  assign dispatch = instr_valid_i && issue_ack_i && !ex_valid_i;

  // ------------------------------
  // ID/EX registers
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_a_o     <= '0;
      operand_b_o     <= '0;
      imm_o           <= '0;
      fu_o            <= NONE;
      op_o            <= '0;
      trans_id_o      <= '0;
      alu_valid_o     <= 1'b0;
      branch_valid_o  <= 1'b0;
      mult_valid_o    <= 1'b0;
      lsu_valid_o     <= 1'b0;
      csr_valid_o     <= 1'b0;
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
      bp_taken_o      <= 1'b0;
    end else begin
      // data follows the scoreboard head every cycle
      operand_a_o <= operand_a_d;
      operand_b_o <= operand_b_d;
      imm_o       <= instr_imm_i;
      fu_o        <= instr_fu_i;
      op_o        <= instr_op_i;
      trans_id_o  <= instr_trans_id_i;

      // one-cycle pulse for the selected unit, killed by a flush
      alu_valid_o    <= dispatch && !flush_i && instr_fu_i == ALU;
      branch_valid_o <= dispatch && !flush_i && instr_fu_i == CTRL_FLOW;
      mult_valid_o   <= dispatch && !flush_i && instr_fu_i == MULT;
      lsu_valid_o    <= dispatch && !flush_i &&
                        (instr_fu_i == LOAD || instr_fu_i == STORE);
      csr_valid_o    <= dispatch && !flush_i && instr_fu_i == CSR;

      // branch info held until the next control-flow op
      if (instr_fu_i == CTRL_FLOW) begin
        pc_o            <= instr_pc_i;
        is_compressed_o <= is_compressed_i;
        bp_taken_o      <= bp_taken_i;
      end
    end
  end

  // issue control needs the mult slot occupancy
  assign mult_issued_o = mult_valid_o;

endmodule

//--- source/issue_read_operands.sv
// ------------------------------
// operand-read and issue stage, top level
// ------------------------------

module issue_read_operands #(
  parameter int unsigned XLEN = 32,
  parameter int unsigned VLEN = 32
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  // scoreboard head
  input  logic                                    instr_valid_i,
  input  issue_pkg::fu_t                          instr_fu_i,
  input  logic [issue_pkg::FU_OP_W-1:0]           instr_op_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]        instr_rs1_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]        instr_rs2_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]        instr_rd_i,
  input  logic [XLEN-1:0]                         instr_imm_i,
  input  logic [VLEN-1:0]                         instr_pc_i,
  input  logic [issue_pkg::TRANS_ID_W-1:0]        instr_trans_id_i,
  input  logic                                    use_imm_i,
  input  logic                                    use_pc_i,
  input  logic                                    use_zimm_i,
  input  logic                                    is_compressed_i,
  input  logic                                    ex_valid_i,
  input  logic                                    bp_taken_i,
  input  issue_pkg::fu_t [issue_pkg::NR_REGS-1:0] rd_clobber_i,
  output logic                                    issue_ack_o,
  // scoreboard poll
  output logic [issue_pkg::REG_ADDR_W-1:0]        rs1_o,
  output logic [issue_pkg::REG_ADDR_W-1:0]        rs2_o,
  input  logic [XLEN-1:0]                         rs1_fwd_i,
  input  logic [XLEN-1:0]                         rs2_fwd_i,
  input  logic                                    rs1_fwd_valid_i,
  input  logic                                    rs2_fwd_valid_i,
  // commit port
  input  logic                                    commit_we_i,
  input  logic [issue_pkg::REG_ADDR_W-1:0]        commit_waddr_i,
  input  logic [XLEN-1:0]                         commit_wdata_i,
  // unit ready levels
  input  logic                                    flu_ready_i,
  input  logic                                    lsu_ready_i,
  // ID/EX
  output logic [XLEN-1:0]                         operand_a_o,
  output logic [XLEN-1:0]                         operand_b_o,
  output logic [XLEN-1:0]                         imm_o,
  output issue_pkg::fu_t                          fu_o,
  output logic [issue_pkg::FU_OP_W-1:0]           op_o,
  output logic [issue_pkg::TRANS_ID_W-1:0]        trans_id_o,
  output logic                                    alu_valid_o,
  output logic                                    branch_valid_o,
  output logic                                    mult_valid_o,
  output logic                                    lsu_valid_o,
  output logic                                    csr_valid_o,
  output logic [VLEN-1:0]                         pc_o,
  output logic                                    is_compressed_o,
  output logic                                    bp_taken_o
);

  logic            issue_ack;
  logic            fwd_rs1;
  logic            fwd_rs2;
  logic            mult_issued;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;

  // scoreboard is polled with the raw source fields
  assign rs1_o       = instr_rs1_i;
  assign rs2_o       = instr_rs2_i;
  assign issue_ack_o = issue_ack;

  issue_ctrl u_issue_ctrl (
    .instr_valid_i   (instr_valid_i),
    .instr_fu_i      (instr_fu_i),
    .instr_rs1_i     (instr_rs1_i),
    .instr_rs2_i     (instr_rs2_i),
    .instr_rd_i      (instr_rd_i),
    .use_zimm_i      (use_zimm_i),
    .ex_valid_i      (ex_valid_i),
    .rd_clobber_i    (rd_clobber_i),
    .rs1_fwd_valid_i (rs1_fwd_valid_i),
    .rs2_fwd_valid_i (rs2_fwd_valid_i),
    .commit_we_i     (commit_we_i),
    .commit_waddr_i  (commit_waddr_i),
    .flu_ready_i     (flu_ready_i),
    .lsu_ready_i     (lsu_ready_i),
    .mult_issued_i   (mult_issued),
    .issue_ack_o     (issue_ack),
    .fwd_rs1_o       (fwd_rs1),
    .fwd_rs2_o       (fwd_rs2)
  );

  int_regfile #(
    .XLEN (XLEN)
  ) u_int_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (instr_rs1_i),
    .raddr_b_i (instr_rs2_i),
    .we_i      (commit_we_i),
    .waddr_i   (commit_waddr_i),
    .wdata_i   (commit_wdata_i),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  operand_dispatch #(
    .XLEN (XLEN),
    .VLEN (VLEN)
  ) u_operand_dispatch (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .issue_ack_i      (issue_ack),
    .fwd_rs1_i        (fwd_rs1),
    .fwd_rs2_i        (fwd_rs2),
    .rdata_a_i        (rdata_a),
    .rdata_b_i        (rdata_b),
    .rs1_fwd_i        (rs1_fwd_i),
    .rs2_fwd_i        (rs2_fwd_i),
    .instr_valid_i    (instr_valid_i),
    .ex_valid_i       (ex_valid_i),
    .instr_fu_i       (instr_fu_i),
    .instr_op_i       (instr_op_i),
    .instr_rs1_i      (instr_rs1_i),
    .instr_imm_i      (instr_imm_i),
    .instr_pc_i       (instr_pc_i),
    .instr_trans_id_i (instr_trans_id_i),
    .use_imm_i        (use_imm_i),
    .use_pc_i         (use_pc_i),
    .use_zimm_i       (use_zimm_i),
    .is_compressed_i  (is_compressed_i),
    .bp_taken_i       (bp_taken_i),
    .operand_a_o      (operand_a_o),
    .operand_b_o      (operand_b_o),
    .imm_o            (imm_o),
    .fu_o             (fu_o),
    .op_o             (op_o),
    .trans_id_o       (trans_id_o),
    .alu_valid_o      (alu_valid_o),
    .branch_valid_o   (branch_valid_o),
    .mult_valid_o     (mult_valid_o),
    .lsu_valid_o      (lsu_valid_o),
    .csr_valid_o      (csr_valid_o),
    .mult_issued_o    (mult_issued),
    .pc_o             (pc_o),
    .is_compressed_o  (is_compressed_o),
    .bp_taken_o       (bp_taken_o)
  );

endmodule

//--- testbench/tb_issue_read_operands.sv
// ------------------------------
// testbench of the issue stage
// case-file driver, checks, watchdog, report
// ------------------------------

module tb_issue_read_operands;

  timeunit 1ns;
  timeprecision 100ps;

  import issue_pkg::*;

  localparam int unsigned XLEN = 32;
  localparam int unsigned VLEN = 32;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY = 2;
  localparam int SEED = 18;
  localparam int MAX_CASES = 64;
  localparam int CYCLES_PER_CASE = 20;
  localparam string CASE_FILE = "testbench/issue_cases.txt";

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  instr_valid_i;
  fu_t                   instr_fu_i;
  logic [FU_OP_W-1:0]    instr_op_i;
  logic [REG_ADDR_W-1:0] instr_rs1_i;
  logic [REG_ADDR_W-1:0] instr_rs2_i;
  logic [REG_ADDR_W-1:0] instr_rd_i;
  logic [XLEN-1:0]       instr_imm_i;
  logic [VLEN-1:0]       instr_pc_i;
  logic [TRANS_ID_W-1:0] instr_trans_id_i;
  logic                  use_imm_i;
  logic                  use_pc_i;
  logic                  use_zimm_i;
  logic                  is_compressed_i;
  logic                  ex_valid_i;
  logic                  bp_taken_i;
  fu_t [NR_REGS-1:0]     rd_clobber_i;
  logic                  issue_ack_o;
  logic [REG_ADDR_W-1:0] rs1_o;
  logic [REG_ADDR_W-1:0] rs2_o;
  logic [XLEN-1:0]       rs1_fwd_i;
  logic [XLEN-1:0]       rs2_fwd_i;
  logic                  rs1_fwd_valid_i;
  logic                  rs2_fwd_valid_i;
  logic                  commit_we_i;
  logic [REG_ADDR_W-1:0] commit_waddr_i;
  logic [XLEN-1:0]       commit_wdata_i;
  logic                  flu_ready_i;
  logic                  lsu_ready_i;
  logic [XLEN-1:0]       operand_a_o;
  logic [XLEN-1:0]       operand_b_o;
  logic [XLEN-1:0]       imm_o;
  fu_t                   fu_o;
  logic [FU_OP_W-1:0]    op_o;
  logic [TRANS_ID_W-1:0] trans_id_o;
  logic                  alu_valid_o;
  logic                  branch_valid_o;
  logic                  mult_valid_o;
  logic                  lsu_valid_o;
  logic                  csr_valid_o;
  logic [VLEN-1:0]       pc_o;
  logic                  is_compressed_o;
  logic                  bp_taken_o;

  // ------------------------------
  // case table with one entry per line
  // ------------------------------

  string       case_name  [MAX_CASES];
  logic [2:0]  case_fu    [MAX_CASES];
  logic [4:0]  case_rs1   [MAX_CASES];
  logic [4:0]  case_rs2   [MAX_CASES];
  logic [4:0]  case_rd    [MAX_CASES];
  logic [31:0] case_imm   [MAX_CASES];
  logic [31:0] case_pc    [MAX_CASES];
  // valid, imm, pc, zimm, rvc, ex, bp from bit 0 up
  logic [7:0]  case_flags [MAX_CASES];
  logic [4:0]  case_clreg [MAX_CASES];
  logic [2:0]  case_clfu  [MAX_CASES];
  logic [3:0]  case_fwdv  [MAX_CASES];
  logic [31:0] case_fwd   [MAX_CASES];
  logic        case_cwe   [MAX_CASES];
  logic [4:0]  case_cwa   [MAX_CASES];
  logic [31:0] case_cwd   [MAX_CASES];
  // flu ready, lsu ready, flush
  logic [3:0]  case_ctrl  [MAX_CASES];
  // unit valids in bits 4:0 and ack in bit 5
  logic [7:0]  case_exp   [MAX_CASES];
  logic [3:0]  case_mask  [MAX_CASES];
  logic [31:0] case_opa   [MAX_CASES];
  logic [31:0] case_opb   [MAX_CASES];

  int n_cases = 0;
  int errors = 0;
  int test_errors = 0;
  int tests_failed = 0;
  // random don't-care fields of the current case
  logic [FU_OP_W-1:0]    drv_op;
  logic [TRANS_ID_W-1:0] drv_tid;

  issue_read_operands #(
    .XLEN (XLEN),
    .VLEN (VLEN)
  ) u_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the case file %s", CASE_FILE);
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      void'($fgets(line, fd));
      // blank lines and column notes
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    case_name[n_cases], case_fu[n_cases], case_rs1[n_cases],
                    case_rs2[n_cases], case_rd[n_cases], case_imm[n_cases],
                    case_pc[n_cases], case_flags[n_cases], case_clreg[n_cases],
                    case_clfu[n_cases], case_fwdv[n_cases], case_fwd[n_cases],
                    case_cwe[n_cases], case_cwa[n_cases], case_cwd[n_cases],
                    case_ctrl[n_cases], case_exp[n_cases], case_mask[n_cases],
                    case_opa[n_cases], case_opb[n_cases]);
      if (cnt != 20) begin
        $display("malformed line in the case file: %s", line);
        errors++;
      end else begin
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  // every input at a quiet level with reset asserted
  task automatic apply_idle();
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    instr_valid_i    = 1'b0;
    instr_fu_i       = NONE;
    instr_op_i       = '0;
    instr_rs1_i      = '0;
    instr_rs2_i      = '0;
    instr_rd_i       = '0;
    instr_imm_i      = '0;
    instr_pc_i       = '0;
    instr_trans_id_i = '0;
    use_imm_i        = 1'b0;
    use_pc_i         = 1'b0;
    use_zimm_i       = 1'b0;
    is_compressed_i  = 1'b0;
    ex_valid_i       = 1'b0;
    bp_taken_i       = 1'b0;
    for (int r = 0; r < NR_REGS; r++) begin
      rd_clobber_i[r] = NONE;
    end
    rs1_fwd_i        = '0;
    rs2_fwd_i        = '0;
    rs1_fwd_valid_i  = 1'b0;
    rs2_fwd_valid_i  = 1'b0;
    commit_we_i      = 1'b0;
    commit_waddr_i   = '0;
    commit_wdata_i   = '0;
    flu_ready_i      = 1'b1;
    lsu_ready_i      = 1'b1;
  endtask

  task automatic drive_case(input int idx);
    instr_valid_i   = case_flags[idx][0];
    use_imm_i       = case_flags[idx][1];
    use_pc_i        = case_flags[idx][2];
    use_zimm_i      = case_flags[idx][3];
    is_compressed_i = case_flags[idx][4];
    ex_valid_i      = case_flags[idx][5];
    bp_taken_i      = case_flags[idx][6];
    instr_fu_i      = fu_t'(case_fu[idx]);
    instr_rs1_i     = case_rs1[idx];
    instr_rs2_i     = case_rs2[idx];
    instr_rd_i      = case_rd[idx];
    instr_imm_i     = case_imm[idx];
    instr_pc_i      = case_pc[idx];
    // op, id and the unused rs2 forward value are don't-care
    drv_op           = FU_OP_W'($urandom);
    drv_tid          = TRANS_ID_W'($urandom);
    instr_op_i       = drv_op;
    instr_trans_id_i = drv_tid;
    rs2_fwd_i        = $urandom;
    // single pending producer at most
    for (int r = 0; r < NR_REGS; r++) begin
      rd_clobber_i[r] = NONE;
    end
    if (case_clfu[idx] != 3'd0) begin
      rd_clobber_i[case_clreg[idx]] = fu_t'(case_clfu[idx]);
    end
    rs1_fwd_valid_i = case_fwdv[idx][0];
    rs2_fwd_valid_i = case_fwdv[idx][1];
    rs1_fwd_i       = case_fwd[idx];
    commit_we_i     = case_cwe[idx];
    commit_waddr_i  = case_cwa[idx];
    commit_wdata_i  = case_cwd[idx];
    flu_ready_i     = case_ctrl[idx][0];
    lsu_ready_i     = case_ctrl[idx][1];
    flush_i         = case_ctrl[idx][2];
  endtask

  // ack is checked mid-cycle and the registered outputs after the next edge
  task automatic run_case(input int idx);
    test_errors = 0;
    drive_case(idx);
    @(negedge clk_i);
    compare_value("issue_ack_o", 32'(issue_ack_o), 32'(case_exp[idx][5]));
    compare_value("rs1_o", 32'(rs1_o), 32'(case_rs1[idx]));
    compare_value("rs2_o", 32'(rs2_o), 32'(case_rs2[idx]));
    @(posedge clk_i);
    #1;
    compare_value("unit valids",
                  32'({csr_valid_o, lsu_valid_o, mult_valid_o, branch_valid_o, alu_valid_o}),
                  32'(case_exp[idx][4:0]));
    compare_value("fu_o", 32'(fu_o), 32'(case_fu[idx]));
    compare_value("op_o", 32'(op_o), 32'(drv_op));
    compare_value("trans_id_o", 32'(trans_id_o), 32'(drv_tid));
    compare_value("imm_o", imm_o, case_imm[idx]);
    if (case_mask[idx][0]) begin
      compare_value("operand_a_o", operand_a_o, case_opa[idx]);
    end
    if (case_mask[idx][1]) begin
      compare_value("operand_b_o", operand_b_o, case_opb[idx]);
    end
    if (case_mask[idx][2]) begin
      compare_value("pc_o", pc_o, case_pc[idx]);
      compare_value("is_compressed_o", 32'(is_compressed_o), 32'(case_flags[idx][4]));
      compare_value("bp_taken_o", 32'(bp_taken_o), 32'(case_flags[idx][6]));
    end
    if (test_errors == 0) begin
      $display("test %0d %s: ok", idx, case_name[idx]);
    end else begin
      $display("test %0d %s: FAILED", idx, case_name[idx]);
      tests_failed++;
    end
    #(DRIVE_DELAY - 1);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin : main
    void'($urandom(SEED));
    apply_idle();
    load_cases();
    if (n_cases == 0) begin
      $display("no test cases could be read from %s", CASE_FILE);
      $display("Checks failed");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk_i);
      #1;
      // everything registered is cleared while in reset
      test_errors = 0;
      compare_value("valids in reset",
                    32'({csr_valid_o, lsu_valid_o, mult_valid_o, branch_valid_o, alu_valid_o}),
                    32'd0);
      compare_value("operand_a_o in reset", operand_a_o, 32'd0);
      compare_value("operand_b_o in reset", operand_b_o, 32'd0);
      compare_value("imm_o in reset", imm_o, 32'd0);
      compare_value("fu_o in reset", 32'(fu_o), 32'd0);
      compare_value("op_o in reset", 32'(op_o), 32'd0);
      compare_value("trans_id_o in reset", 32'(trans_id_o), 32'd0);
      compare_value("pc_o in reset", pc_o, 32'd0);
      compare_value("is_compressed_o in reset", 32'(is_compressed_o), 32'd0);
      compare_value("bp_taken_o in reset", 32'(bp_taken_o), 32'd0);
      $display("reset: %s", test_errors == 0 ? "ok" : "FAILED");
      #(DRIVE_DELAY - 1);
      rst_ni = 1'b1;
      @(posedge clk_i);
      #DRIVE_DELAY;
      for (int i = 0; i < n_cases; i++) begin
        run_case(i);
      end
      $display("summary: %0d tests run, %0d failed, %0d check errors",
               n_cases, tests_failed, errors);
      if (errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

  // ------------------------------
  // watchdog scaled by the case count
  // ------------------------------

  initial begin : watchdog
    wait (n_cases > 0);
    #((RESET_CYCLES + n_cases * CYCLES_PER_CASE) * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in time");
    $display("Checks failed");
    $finish;
  end

endmodule

//--- testbench/issue_cases.txt
# name fu rs1 rs2 rd imm pc flags clreg clfu fwdv fwd cwe cwa cwd ctrl exp mask opa opb
# flags 0 valid 1 imm 2 pc 3 zimm 4 rvc 5 ex 6 bp, ctrl 0 flu 1 lsu 2 flush, exp 5 ack 4:0 units
pre_x1   0 00 00 00 00000000 00000000 00 00 0 0 00000000 1 01 1234abcd 3 00 0 00000000 00000000
pre_x2   0 00 00 00 00000000 00000000 00 00 0 0 00000000 1 02 cafe0002 3 00 0 00000000 00000000
alu_rr   3 01 02 03 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 21 3 1234abcd cafe0002
alu_x0   3 00 01 04 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 21 3 00000000 1234abcd
raw_fwd  3 01 02 05 00000000 00000000 01 01 1 1 0badf00d 0 00 00000000 3 21 3 0badf00d cafe0002
raw_inv  3 01 02 05 00000000 00000000 01 01 1 0 0badf00d 0 00 00000000 3 00 1 1234abcd 00000000
raw_csr  3 01 02 05 00000000 00000000 01 01 6 1 0badf00d 0 00 00000000 3 00 1 1234abcd 00000000
waw_blk  3 01 02 07 00000000 00000000 01 07 3 0 00000000 0 00 00000000 3 00 0 00000000 00000000
waw_cmt  3 01 02 07 00000000 00000000 01 07 3 0 00000000 1 07 00000077 3 21 3 1234abcd cafe0002
ld_busy  1 01 02 08 00000000 00000000 01 00 0 0 00000000 0 00 00000000 1 00 0 00000000 00000000
st_busy  2 01 02 00 00000000 00000000 01 00 0 0 00000000 0 00 00000000 1 00 0 00000000 00000000
alu_busy 3 01 02 08 00000000 00000000 01 00 0 0 00000000 0 00 00000000 2 00 0 00000000 00000000
br_busy  4 01 02 00 00000000 00000000 01 00 0 0 00000000 0 00 00000000 2 00 0 00000000 00000000
csr_busy 6 01 02 08 00000000 00000000 01 00 0 0 00000000 0 00 00000000 2 00 0 00000000 00000000
mul_busy 5 01 02 08 00000000 00000000 01 00 0 0 00000000 0 00 00000000 2 00 0 00000000 00000000
ld_imm   1 01 02 08 00000010 00000000 03 00 0 0 00000000 0 00 00000000 3 28 3 1234abcd 00000010
mul_1    5 01 02 09 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 24 3 1234abcd cafe0002
mul_2    5 01 02 0a 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 24 0 00000000 00000000
alu_mul  3 01 02 0b 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 00 0 00000000 00000000
alu_ok   3 01 02 0b 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 21 3 1234abcd cafe0002
exc      3 01 02 0b 00000000 00000000 21 00 0 0 00000000 0 00 00000000 3 20 0 00000000 00000000
fu_none  0 01 02 0b 00000000 00000000 01 00 0 0 00000000 0 00 00000000 3 20 0 00000000 00000000
flush    3 01 02 0b 00000000 00000000 01 00 0 0 00000000 0 00 00000000 7 20 0 00000000 00000000
use_pc   3 01 02 0c 00000000 80001000 05 00 0 0 00000000 0 00 00000000 3 21 1 80001000 00000000
zimm     6 1b 00 0d 00000000 00000000 09 00 0 0 00000000 0 00 00000000 3 30 1 0000001b 00000000
imm_alu  3 01 02 0e fffff800 00000000 03 00 0 0 00000000 0 00 00000000 3 21 3 1234abcd fffff800
imm_st   2 01 02 00 00000040 00000000 03 00 0 0 00000000 0 00 00000000 3 28 2 00000000 cafe0002
branch   4 01 02 00 00000010 00002000 53 00 0 0 00000000 0 00 00000000 3 22 7 1234abcd cafe0002

//--- src.f
source/issue_pkg.sv
source/issue_ctrl.sv
source/int_regfile.sv
source/operand_dispatch.sv
source/issue_read_operands.sv
testbench/tb_issue_read_operands.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_issue_read_operands -f src.f -o tb_issue_read_operands

./obj_dir/tb_issue_read_operands > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0
